// ==== Makefile ====
SRCS := $(shell grep -v '^+' datapath.f)

obj_dir/Vtb_datapath: datapath.f $(SRCS) rv32i_defines.svh sim/tb_model.svh
	verilator --binary --timing --assert --top-module tb_datapath -f datapath.f -o Vtb_datapath

run: obj_dir/Vtb_datapath
	@out="$$(./obj_dir/Vtb_datapath)"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== datapath.f ====
+incdir+.
+incdir+sim
hw/rv32i_pkg.sv
hw/control_unit.sv
hw/regfile.sv
hw/alu.sv
hw/mem_align.sv
hw/datapath.sv
sim/tb_datapath.sv

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu import rv32i_pkg::*; (
    input  alu_ops    aluop,
    input  rv32i_word a,
    input  rv32i_word b,
    output rv32i_word f
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            // compares give 0 or 1
            alu_slt:  f = rv32i_word'($signed(a) < $signed(b));
            alu_sltu: f = rv32i_word'(a < b);
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = rv32i_word'($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/100ps

module control_unit import rv32i_pkg::*; (
    input  rv32i_word         instr,
    output rv32i_control_word ctrl_word,
    output logic              illegal
);
    rv32i_opcode       opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              alt;
    rv32i_control_word ctrl;

    assign opcode = rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    // funct7 marker of sub and sra
    assign alt = (funct7 == 7'b0100000);

    function automatic alu_ops alu_of(input logic [2:0] f3, input logic alt_op);
        case (f3)
            3'b000:  return alt_op ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt_op ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl = ctrl_nop;
        ctrl.instr = instr;
        ctrl.dest = instr[11:7];
        ctrl.funct3 = funct3;
        illegal = 1'b0;
        case (opcode)
            op_lui, op_auipc: begin
                ctrl.op1_sel = (opcode == op_auipc) ? op1_pc : op1_rs1;
                ctrl.op2_sel = op2_u_imm;
                ctrl.load_regfile = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op = alu_of(funct3, alt && funct3 == 3'b101);
                ctrl.load_regfile = 1'b1;
                // only srai may set a funct7 bit
                if (funct3 == 3'b001 && funct7 != '0)
                    illegal = 1'b1;
                if (funct3 == 3'b101 && funct7 != '0 && !alt)
                    illegal = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op = alu_of(funct3, alt);
                ctrl.op2_sel = op2_rs2;
                ctrl.load_regfile = 1'b1;
                if (funct7 != '0 && !(alt && (funct3 == 3'b000 || funct3 == 3'b101)))
                    illegal = 1'b1;
            end
            op_load: begin
                ctrl.mem_read = 1'b1;
                ctrl.load_regfile = 1'b1;
                case (funct3)
                    3'b000:  ctrl.wb_sel = wb_lb;
                    3'b001:  ctrl.wb_sel = wb_lh;
                    3'b010:  ctrl.wb_sel = wb_lw;
                    3'b100:  ctrl.wb_sel = wb_lbu;
                    3'b101:  ctrl.wb_sel = wb_lhu;
                    default: illegal = 1'b1;
                endcase
            end
            op_store: begin
                ctrl.op2_sel = op2_s_imm;
                ctrl.mem_write = 1'b1;
                if (funct3 > 3'b010)
                    illegal = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        ctrl_word = illegal ? ctrl_nop : ctrl;
    end

    always_comb begin
        assert (!(ctrl_word.mem_read && ctrl_word.mem_write))
            else $error("decode enabled a load and a store together");
    end

endmodule

// ==== hw/datapath.sv ====
`timescale 1ns/100ps
`include "rv32i_defines.svh"

module datapath import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  rv32i_word  inst_rdata,
    output rv32i_word  inst_addr,
    output logic       inst_read,
    input  rv32i_word  data_rdata,
    output rv32i_word  data_wdata,
    output rv32i_word  data_addr,
    output logic [3:0] data_mbe,
    output logic       data_read,
    output logic       data_write
);
    // fetch and decode
    rv32i_word         pc_q;
    rv32i_word         pc_id;
    rv32i_word         instr_id;
    rv32i_control_word ctrl_id;
    logic              illegal_id;
    reg_idx_t          rs1_idx;
    rv32i_word         rs1_data;
    rv32i_word         rs2_data;
    // execute
    rv32i_control_word ctrl_ex;
    logic              illegal_ex;
    rv32i_word         pc_ex;
    rv32i_word         rs1_ex;
    rv32i_word         rs2_ex;
    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         u_imm;
    rv32i_word         op1;
    rv32i_word         op2;
    rv32i_word         alu_out;
    // memory and writeback
    rv32i_control_word ctrl_mem;
    rv32i_word         alu_mem;
    rv32i_word         rs2_mem;
    rv32i_control_word ctrl_wb;
    rv32i_word         alu_wb;
    rv32i_word         rdata_wb;
    rv32i_word         load_value;
    rv32i_word         wb_value;

    assign inst_read = 1'b1;
    assign inst_addr = pc_q;
    assign data_addr = alu_mem;
    assign data_read = ctrl_mem.mem_read;
    assign data_write = ctrl_mem.mem_write;

    // control state, banks reset to a nop so nothing reaches memory early
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RV_RESET_PC;
            instr_id <= nop_instr;
            ctrl_ex <= ctrl_nop;
            illegal_ex <= 1'b0;
            ctrl_mem <= ctrl_nop;
            ctrl_wb <= ctrl_nop;
        end else begin
            pc_q <= pc_q + 32'd4;
            instr_id <= inst_rdata;
            ctrl_ex <= ctrl_id;
            illegal_ex <= illegal_id;
            ctrl_mem <= ctrl_ex;
            ctrl_wb <= ctrl_mem;
        end
    end

    always_ff @(posedge clk) begin
        pc_id <= pc_q;
        pc_ex <= pc_id;
        rs1_ex <= rs1_data;
        rs2_ex <= rs2_data;
        alu_mem <= alu_out;
        rs2_mem <= rs2_ex;
        alu_wb <= alu_mem;
        rdata_wb <= data_rdata;
    end

    control_unit u_control (
        .instr     (instr_id),
        .ctrl_word (ctrl_id),
        .illegal   (illegal_id)
    );

    // lui has immediate bits in the rs1 field, read x0 instead
    assign rs1_idx = (ctrl_id.op2_sel == op2_u_imm && ctrl_id.op1_sel == op1_rs1) ?
                     '0 : instr_id[19:15];

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (ctrl_wb.load_regfile),
        .wr_data (wb_value),
        .src_a   (rs1_idx),
        .src_b   (instr_id[24:20]),
        .dest    (ctrl_wb.dest),
        .reg_a   (rs1_data),
        .reg_b   (rs2_data)
    );

    assign i_imm = {{20{ctrl_ex.instr[31]}}, ctrl_ex.instr[31:20]};
    assign s_imm = {{20{ctrl_ex.instr[31]}}, ctrl_ex.instr[31:25], ctrl_ex.instr[11:7]};
    assign u_imm = {ctrl_ex.instr[31:12], 12'h000};

    assign op1 = (ctrl_ex.op1_sel == op1_pc) ? pc_ex : rs1_ex;

    always_comb begin
        case (ctrl_ex.op2_sel)
            op2_s_imm: op2 = s_imm;
            op2_u_imm: op2 = u_imm;
            op2_rs2:   op2 = rs2_ex;
            default:   op2 = i_imm;
        endcase
    end

    alu u_alu (
        .aluop (ctrl_ex.alu_op),
        .a     (op1),
        .b     (op2),
        .f     (alu_out)
    );

    // stores are shaped in MEM, loads extended in WB
    mem_align u_mem_align (
        .store_funct3 (ctrl_mem.funct3),
        .addr_lo      (alu_mem[1:0]),
        .store_data   (rs2_mem),
        .wdata        (data_wdata),
        .mbe          (data_mbe),
        .load_funct3  (ctrl_wb.funct3),
        .load_addr_lo (alu_wb[1:0]),
        .rdata        (rdata_wb),
        .load_value   (load_value)
    );

    assign wb_value = (ctrl_wb.wb_sel == wb_alu_out) ? alu_wb : load_value;

    // decode flagged this one a cycle ago
    assert property (@(posedge clk) disable iff (!rst_n) !illegal_ex)
        else $error("illegal instruction reached EX at pc %h", pc_ex);

    assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_mem.mem_write |-> (ctrl_mem.funct3[1:0] == 2'b00) ||
                               (ctrl_mem.funct3[1:0] == 2'b01 && !alu_mem[0]) ||
                               (alu_mem[1:0] == 2'b00))
        else $error("misaligned store to %h", alu_mem);

endmodule

// ==== hw/mem_align.sv ====
`timescale 1ns/100ps

module mem_align import rv32i_pkg::*; (
    input  logic [2:0] store_funct3,
    input  logic [1:0] addr_lo,
    input  rv32i_word  store_data,
    output rv32i_word  wdata,
    output logic [3:0] mbe,
    input  logic [2:0] load_funct3,
    input  logic [1:0] load_addr_lo,
    input  rv32i_word  rdata,
    output rv32i_word  load_value
);
    rv32i_word lane;

    // store side, move the low byte or half up to its lane
    always_comb begin
        case (store_funct3[1:0])
            2'b00: begin
                wdata = rv32i_word'(store_data[7:0]) << {addr_lo, 3'b000};
                mbe = 4'b0001 << addr_lo;
            end
            2'b01: begin
                wdata = rv32i_word'(store_data[15:0]) << {addr_lo[1], 4'b0000};
                mbe = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata = store_data;
                mbe = 4'b1111;
            end
        endcase
    end

    // load side, bring the addressed lane down to bit 0
    assign lane = rdata >> {load_addr_lo, 3'b000};

    always_comb begin
        case (load_funct3)
            3'b000:  load_value = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_value = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_value = {24'h000000, lane[7:0]};
            3'b101:  load_value = {16'h0000, lane[15:0]};
            default: load_value = rdata;
        endcase
    end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/100ps
`include "rv32i_defines.svh"

module regfile import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  rv32i_word wr_data,
    input  reg_idx_t  src_a,
    input  reg_idx_t  src_b,
    input  reg_idx_t  dest,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);
    rv32i_word regs [`RV_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (load && dest != '0) begin
            regs[dest] <= wr_data;
        end
    end

    // writeback in the same cycle is seen by decode
    assign reg_a = (src_a == '0) ? '0 :
                   (load && dest == src_a) ? wr_data : regs[src_a];
    assign reg_b = (src_b == '0) ? '0 :
                   (load && dest == src_b) ? wr_data : regs[src_b];

endmodule

// ==== hw/rv32i_pkg.sv ====
`include "rv32i_defines.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] rv32i_word;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_ops;

    typedef enum logic {op1_rs1, op1_pc} op1_sel_t;

    typedef enum logic [1:0] {op2_i_imm, op2_s_imm, op2_u_imm, op2_rs2} op2_sel_t;

    typedef enum logic [2:0] {wb_alu_out, wb_lb, wb_lh, wb_lw, wb_lbu, wb_lhu} wb_sel_t;

    typedef struct packed {
        rv32i_word  instr;
        alu_ops     alu_op;
        op1_sel_t   op1_sel;
        op2_sel_t   op2_sel;
        wb_sel_t    wb_sel;
        reg_idx_t   dest;
        logic       load_regfile;
        logic       mem_read;
        logic       mem_write;
        // access size for loads and stores
        logic [2:0] funct3;
    } rv32i_control_word;

    // addi x0, x0, 0
    localparam rv32i_word nop_instr = 32'h0000_0013;

    localparam rv32i_control_word ctrl_nop = '{
        instr: nop_instr, alu_op: alu_add, op1_sel: op1_rs1, op2_sel: op2_i_imm,
        wb_sel: wb_alu_out, dest: '0, load_regfile: 1'b0, mem_read: 1'b0,
        mem_write: 1'b0, funct3: 3'b000
    };

endpackage

// ==== rv32i_defines.svh ====
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// data, address and instruction width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [31:0] nop_word = 32'h0000_0013;
localparam int n_items = 120;

logic [31:0] lfsr_q = 32'hb9ce9be0;
logic [31:0] model_regs [32];
logic [31:0] model_mem [64];
logic [31:0] prog [512];
int          prog_len = 0;
int          n_real = 0;
// kind of data access expected in each cycle
// 1 for a load and 2 for a store
logic [1:0]  acc_kind [512];
logic [31:0] acc_addr [512];
logic [31:0] acc_wdata [512];
logic [3:0]  acc_mbe [512];

// galois form with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], lfsr_bit()};
    return v;
endfunction

function automatic logic [31:0] fill_word(input int i);
    return 32'h9e37_79b9 * 32'(i + 1);
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// stores always use x0 as base
function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, sa < sb};
        3'd3: return {31'd0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            // sign fill only while the whole shift stays signed
            if (alt)
                return sa >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// in-order ISA step for the program word at index idx
function automatic void model_exec(input logic [31:0] ins, input int idx);
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] val;
    logic [2:0]  f3;
    logic        wr;
    int          slot;
    pc = `RV_RESET_PC + 32'(idx) * 32'd4;
    f3 = ins[14:12];
    a = model_regs[ins[19:15]];
    b = model_regs[ins[24:20]];
    slot = idx + 3;
    val = '0;
    wr = 1'b1;
    case (ins[6:0])
        7'b0110111: val = {ins[31:12], 12'h000};
        7'b0010111: val = pc + {ins[31:12], 12'h000};
        7'b0010011: val = alu_ref(f3, f3 == 3'd5 && ins[30], a, {{20{ins[31]}}, ins[31:20]});
        7'b0110011: val = alu_ref(f3, ins[30], a, b);
        7'b0000011: begin
            addr = a + {{20{ins[31]}}, ins[31:20]};
            word = model_mem[addr[7:2]] >> {addr[1:0], 3'b000};
            case (f3)
                3'd0: val = {{24{word[7]}}, word[7:0]};
                3'd1: val = {{16{word[15]}}, word[15:0]};
                3'd4: val = {24'd0, word[7:0]};
                3'd5: val = {16'd0, word[15:0]};
                default: val = word;
            endcase
            acc_kind[slot] = 2'd1;
            acc_addr[slot] = addr;
        end
        default: begin
            wr = 1'b0;
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            acc_kind[slot] = 2'd2;
            acc_addr[slot] = addr;
            acc_wdata[slot] = b << {addr[1:0], 3'b000};
            if (f3 == 3'd0)
                acc_mbe[slot] = 4'b0001 << addr[1:0];
            else if (f3 == 3'd1)
                acc_mbe[slot] = 4'b0011 << addr[1:0];
            else
                acc_mbe[slot] = 4'b1111;
            for (int k = 0; k < 4; k++)
                if (acc_mbe[slot][k])
                    model_mem[addr[7:2]][8*k +: 8] = acc_wdata[slot][8*k +: 8];
        end
    endcase
    if (wr && ins[11:7] != 5'd0)
        model_regs[ins[11:7]] = val;
endfunction

task automatic push_word(input logic [31:0] ins);
    prog[prog_len] = ins;
    model_exec(ins, prog_len);
    prog_len++;
endtask

// two nops keep every producer clear of its consumer
task automatic emit(input logic [31:0] ins);
    push_word(ins);
    push_word(nop_word);
    push_word(nop_word);
    n_real++;
endtask

task automatic gen_item();
    logic [31:0] r;
    logic [11:0] off;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [2:0]  f3;
    logic [1:0]  kind;
    r = rand_bits(2);
    kind = r[1:0];
    r = rand_bits(5);
    rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    r = rand_bits(5);
    rs = r[4:0];
    r = rand_bits(6);
    off = {4'd0, r[5:0], 2'b00};
    if (kind == 2'd1) begin
        // sb or sh from a random register
        r = rand_bits(1);
        f3 = {2'b00, r[0]};
        r = rand_bits(2);
        off[1:0] = (f3 == 3'd0) ? r[1:0] : {r[0], 1'b0};
        emit(s_word(off, rs, f3));
    end else begin
        if (kind == 2'd2) begin
            r = rand_bits(3);
            case (r[2:0])
                3'd0, 3'd5: f3 = 3'd0;
                3'd1, 3'd6: f3 = 3'd1;
                3'd2, 3'd7: f3 = 3'd2;
                3'd3: f3 = 3'd4;
                default: f3 = 3'd5;
            endcase
            r = rand_bits(2);
            if (f3 == 3'd0 || f3 == 3'd4)
                off[1:0] = r[1:0];
            else if (f3 != 3'd2)
                off[1:0] = {r[0], 1'b0};
            emit(i_word(off, 5'd0, f3, rd, 7'b0000011));
        end else begin
            r = rand_bits(2);
            case (r[1:0])
                2'd0: begin
                    r = rand_bits(20);
                    emit({r[19:0], rd, 7'b0110111});
                end
                2'd1: begin
                    r = rand_bits(20);
                    emit({r[19:0], rd, 7'b0010111});
                end
                2'd2: begin
                    r = rand_bits(16);
                    f3 = r[15:13];
                    if (f3 == 3'd1)
                        r[11:5] = 7'd0;
                    else if (f3 == 3'd5)
                        r[11:5] = {1'b0, r[12], 5'd0};
                    emit(i_word(r[11:0], rs, f3, rd, 7'b0010011));
                end
                default: begin
                    r = rand_bits(9);
                    f3 = r[8:6];
                    r[5] = r[5] && (f3 == 3'd0 || f3 == 3'd5);
                    emit({1'b0, r[5], 5'd0, r[4:0], rs, f3, rd, 7'b0110011});
                end
            endcase
        end
        // show the result on the store port
        r = rand_bits(6);
        emit(s_word({4'd0, r[5:0], 2'b00}, rd, 3'd2));
    end
endtask

`endif

// ==== sim/tb_datapath.sv ====
`timescale 1ns/100ps
`include "rv32i_defines.svh"

module tb_datapath import rv32i_pkg::*; ();
    logic       clk;
    logic       rst_n;
    rv32i_word  inst_rdata;
    rv32i_word  inst_addr;
    logic       inst_read;
    rv32i_word  data_rdata;
    rv32i_word  data_wdata;
    rv32i_word  data_addr;
    logic [3:0] data_mbe;
    logic       data_read;
    logic       data_write;
    rv32i_word  dmem [64];

    `include "tb_model.svh"

    datapath UUT (.*);

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len)
            return prog[idx];
        return nop_word;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        inst_rdata = nop_word;
        data_rdata = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 512; i++)
            acc_kind[i] = 2'd0;
        while (n_real < n_items)
            gen_item();
        fork
            begin
                #((3 * n_real + 20) * 10);
                $display("timeout: the program did not drain in time");
                $display("CHECKS FAILED");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    // instruction memory answers from the current pc, data memory a bit later
    always @(posedge clk) begin
        #1;
        inst_rdata = prog_word(inst_addr);
        #1;
        data_rdata = dmem[data_addr[7:2]];
    end

    // mid-cycle checks, cycle 0 is the first one after reset release
    initial begin
        logic [31:0] mask;
        @(posedge rst_n);
        for (int n = 0; n < prog_len + 4; n++) begin
            @(negedge clk);
            check_eq($sformatf("pc cycle %0d", n), `RV_RESET_PC + 32'(4 * n), inst_addr);
            check_eq($sformatf("inst_read cycle %0d", n), 32'd1, {31'd0, inst_read});
            check_eq($sformatf("access flags cycle %0d", n),
                     {30'd0, acc_kind[n] == 2'd1, acc_kind[n] == 2'd2},
                     {30'd0, data_read, data_write});
            if (acc_kind[n] != 2'd0)
                check_eq($sformatf("address cycle %0d", n), acc_addr[n], data_addr);
            if (acc_kind[n] == 2'd2) begin
                check_eq($sformatf("byte enables cycle %0d", n),
                         {28'd0, acc_mbe[n]}, {28'd0, data_mbe});
                mask = {{8{acc_mbe[n][3]}}, {8{acc_mbe[n][2]}},
                        {8{acc_mbe[n][1]}}, {8{acc_mbe[n][0]}}};
                check_eq($sformatf("store data cycle %0d", n),
                         acc_wdata[n] & mask, data_wdata & mask);
                for (int k = 0; k < 4; k++)
                    if (data_mbe[k])
                        dmem[data_addr[7:2]][8*k +: 8] = data_wdata[8*k +: 8];
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
